// ==== accumCpu.f ====
src/isaPkg.sv
src/memPkg.sv
src/wordMemory.sv
src/instrDecode.sv
src/accumulatorAlu.sv
src/controlSequencer.sv
src/storePort.sv
src/cpuTop.sv
tb/cpuTop_chk.sv
tb/storeMonitor.sv
tb/cpuTop_tb.sv

// ==== src/accumulatorAlu.sv ====
`timescale 1ns/10ps

module accumulatorAlu (
  input  logic           clock,
  input  logic           rstN,
  input  logic           clear,
  input  logic           exec,
  input  isaPkg::aluOp_t aluOp,
  input  isaPkg::word_t  operand,
  output isaPkg::word_t  acc,
  output logic           accZero
);
  import isaPkg::*;

  word_t negOperand;
  word_t accNext;

  // Two's complement of the operand for Subt
  assign negOperand = ~operand + word_t'(1);

  // Result of the current action, sums wrap modulo 2^32
  always_comb begin
    case (aluOp)
      aluLoad: accNext = operand;
      aluAdd: accNext = acc + operand;
      aluSub: accNext = acc + negOperand;
      aluAnd: accNext = acc & operand;
      aluOr: accNext = acc | operand;
      aluNot: accNext = ~acc;
      aluClear: accNext = '0;
      default: accNext = acc;
    endcase
  end

  // Accumulator register
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      acc <= '0;
    end else if (clear) begin
      // Fresh run starts from zero
      acc <= '0;
    end else if (exec) begin
      acc <= accNext;
    end
  end

  // Feeds the Skip test
  assign accZero = (acc == '0);

endmodule

// ==== src/controlSequencer.sv ====
`timescale 1ns/10ps

module controlSequencer (
  input  logic             clock,
  input  logic             rstN,
  input  logic             start,
  input  isaPkg::word_t    rdData,
  // Decoded fields of the current instruction
  input  memPkg::memAddr_t operand,
  input  isaPkg::aluOp_t   aluOp,
  input  logic             needsOperand,
  input  logic             isStore,
  input  logic             isSkip,
  input  logic             isJump,
  input  logic             isHalt,
  // Accumulator state
  input  logic             accZero,
  input  isaPkg::word_t    acc,
  input  logic             resultReady,
  output isaPkg::word_t    instr,
  output logic             idle,
  output logic             halted,
  // Memory processor port
  output memPkg::memAddr_t rdAddr,
  output logic             wrEn,
  output memPkg::memAddr_t wrAddr,
  output isaPkg::word_t    wrData,
  // Accumulator control
  output logic             exec,
  output logic             clear,
  output isaPkg::word_t    aluOperand,
  // Store result offer
  output logic             resultValid,
  output memPkg::memAddr_t resultAddr,
  output isaPkg::word_t    resultData
);
  import isaPkg::*;
  import memPkg::*;

  typedef enum logic [2:0] {
    sIdle,
    sFetchAddr,
    sFetchData,
    sOperandAddr,
    sOperandData,
    sExecute,
    sHalted
  } phase_t;

  phase_t state;
  phase_t stateNext;
  memAddr_t pc;
  memAddr_t pcNext;
  word_t irReg;
  word_t mbr;
  logic inExecute;

  assign idle = (state == sIdle);
  assign halted = (state == sHalted);
  assign inExecute = (state == sExecute);
  // Accumulator cleared on the start pulse
  assign clear = idle && start;

  // Decode sees the fetched word as it arrives so the next phase can be chosen
  assign instr = (state == sFetchData) ? rdData : irReg;

  // Instruction address except while reading the operand
  assign rdAddr = (state == sOperandAddr) ? operand : pc;

  // Store offered in execute, memory written on the handshake
  assign resultValid = inExecute && isStore;
  assign resultAddr = operand;
  assign resultData = acc;
  assign wrEn = resultValid && resultReady;
  assign wrAddr = operand;
  assign wrData = acc;

  // Accumulator update only for instructions that change it
  assign exec = inExecute && (aluOp != aluHold);
  assign aluOperand = mbr;

  // Next program counter
  always_comb begin
    if (isJump) begin
      pcNext = operand;
    end else if (isSkip && accZero) begin
      pcNext = pc + memAddr_t'(2);
    end else begin
      pcNext = pc + memAddr_t'(1);
    end
  end

  // Phase machine
  always_comb begin
    stateNext = state;
    case (state)
      sIdle: if (start) stateNext = sFetchAddr;
      sFetchAddr: stateNext = sFetchData;
      sFetchData: stateNext = needsOperand ? sOperandAddr : sExecute;
      sOperandAddr: stateNext = sOperandData;
      sOperandData: stateNext = sExecute;
      sExecute: begin
        // Store stalls here until the result is taken
        if (isHalt) begin
          stateNext = sHalted;
        end else if (!isStore || resultReady) begin
          stateNext = sFetchAddr;
        end
      end
      // Stays halted until reset
      sHalted: stateNext = sHalted;
      default: stateNext = sIdle;
    endcase
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= sIdle;
      pc <= '0;
    end else begin
      state <= stateNext;
      if (clear) begin
        // Run begins at address 0
        pc <= '0;
      end else if (inExecute && stateNext == sFetchAddr) begin
        pc <= pcNext;
      end
    end
  end

  // Instruction and operand words
  always_ff @(posedge clock) begin
    if (state == sFetchData) begin
      irReg <= rdData;
    end
    if (state == sOperandData) begin
      mbr <= rdData;
    end
  end

endmodule

// ==== src/cpuTop.sv ====
`timescale 1ns/10ps

module cpuTop (
  input  logic             clock,
  input  logic             rstN,
  input  logic             start,
  // Program load
  input  logic             loadValid,
  input  memPkg::memAddr_t loadAddr,
  input  isaPkg::word_t    loadData,
  output logic             loadReady,
  // Store results
  input  logic             storeReady,
  output logic             storeValid,
  output memPkg::memAddr_t storeAddr,
  output isaPkg::word_t    storeData,
  // Status
  output logic             halted,
  output isaPkg::word_t    acc
);
  import isaPkg::*;
  import memPkg::*;

  logic idle;
  logic loadEn;
  memAddr_t rdAddr;
  memAddr_t wrAddr;
  memAddr_t operand;
  memAddr_t resultAddr;
  word_t rdData;
  word_t wrData;
  word_t instr;
  word_t aluOperand;
  word_t resultData;
  aluOp_t aluOp;
  logic wrEn;
  logic needsOperand;
  logic isStore;
  logic isSkip;
  logic isJump;
  logic isHalt;
  logic exec;
  logic clear;
  logic accZero;
  logic resultValid;
  logic resultReady;

  // Loads accepted only before the run
  assign loadReady = idle;
  assign loadEn = loadValid && idle;

  wordMemory i_wordMemory (
    .clock(clock), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .rdAddr(rdAddr), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .rdData(rdData)
  );

  controlSequencer i_controlSequencer (
    .clock(clock), .rstN(rstN), .start(start), .rdData(rdData), .operand(operand),
    .aluOp(aluOp), .needsOperand(needsOperand), .isStore(isStore), .isSkip(isSkip),
    .isJump(isJump), .isHalt(isHalt), .accZero(accZero), .acc(acc),
    .resultReady(resultReady), .instr(instr), .idle(idle), .halted(halted),
    .rdAddr(rdAddr), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .exec(exec),
    .clear(clear), .aluOperand(aluOperand), .resultValid(resultValid),
    .resultAddr(resultAddr), .resultData(resultData)
  );

  instrDecode i_instrDecode (
    .instr(instr), .operand(operand), .aluOp(aluOp), .needsOperand(needsOperand),
    .isStore(isStore), .isSkip(isSkip), .isJump(isJump), .isHalt(isHalt)
  );

  accumulatorAlu i_accumulatorAlu (
    .clock(clock), .rstN(rstN), .clear(clear), .exec(exec), .aluOp(aluOp),
    .operand(aluOperand), .acc(acc), .accZero(accZero)
  );

  storePort i_storePort (
    .clock(clock), .rstN(rstN), .inValid(resultValid), .inAddr(resultAddr),
    .inData(resultData), .inReady(resultReady), .outReady(storeReady),
    .outValid(storeValid), .outAddr(storeAddr), .outData(storeData)
  );

endmodule

// ==== src/instrDecode.sv ====
`timescale 1ns/10ps

module instrDecode (
  input  isaPkg::word_t    instr,
  output memPkg::memAddr_t operand,
  output isaPkg::aluOp_t   aluOp,
  output logic             needsOperand,
  output logic             isStore,
  output logic             isSkip,
  output logic             isJump,
  output logic             isHalt
);
  import isaPkg::*;
  import memPkg::*;

  opcode_t opcode;
  logic [operandBits-1:0] addrField;

  // Opcode on top, address field below
  assign opcode = instr[wordBits-1 -: opcodeBits];
  assign addrField = instr[operandBits-1:0];
  // Only the low address bits reach the memory
  assign operand = addrField[memAddrBits-1:0];

  // Instruction class per opcode
  always_comb begin
    aluOp = aluHold;
    needsOperand = 1'b0;
    isStore = 1'b0;
    isSkip = 1'b0;
    isJump = 1'b0;
    isHalt = 1'b0;
    case (opcode)
      // Memory read plus accumulator update
      opAdd: begin
        aluOp = aluAdd;
        needsOperand = 1'b1;
      end
      opSubt: begin
        aluOp = aluSub;
        needsOperand = 1'b1;
      end
      opAnd: begin
        aluOp = aluAnd;
        needsOperand = 1'b1;
      end
      opOr: begin
        aluOp = aluOr;
        needsOperand = 1'b1;
      end
      opLoad: begin
        aluOp = aluLoad;
        needsOperand = 1'b1;
      end
      // Accumulator only
      opNot: aluOp = aluNot;
      opClear: aluOp = aluClear;
      // Control flow and output
      opStore: isStore = 1'b1;
      opSkip: isSkip = 1'b1;
      opJump: isJump = 1'b1;
      opHalt: isHalt = 1'b1;
      // Anything else runs as a no-op
      default: aluOp = aluHold;
    endcase
  end

endmodule

// ==== src/isaPkg.sv ====
package isaPkg;

  // Word and field widths
  localparam int wordBits = 32;
  localparam int opcodeBits = 4;
  // Address field sits below the opcode
  localparam int operandBits = 28;

  typedef logic [wordBits-1:0] word_t;
  typedef logic [opcodeBits-1:0] opcode_t;

  // Opcode values, top four bits of the instruction
  localparam opcode_t opAdd = 4'd0;
  localparam opcode_t opSubt = 4'd1;
  localparam opcode_t opAnd = 4'd2;
  localparam opcode_t opOr = 4'd3;
  localparam opcode_t opNot = 4'd4;
  localparam opcode_t opHalt = 4'd5;
  localparam opcode_t opLoad = 4'd6;
  localparam opcode_t opStore = 4'd7;
  localparam opcode_t opClear = 4'd8;
  localparam opcode_t opSkip = 4'd9;
  localparam opcode_t opJump = 4'd10;

  // Accumulator action chosen by decode
  typedef enum logic [2:0] {
    aluHold,
    aluLoad,
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluNot,
    aluClear
  } aluOp_t;

endpackage

// ==== src/memPkg.sv ====
package memPkg;

  // Word addressed memory, program and data share it
  localparam int memAddrBits = 8;
  localparam int memWords = 1 << memAddrBits;

  // Low bits of the instruction address field
  typedef logic [memAddrBits-1:0] memAddr_t;

endpackage

// ==== src/storePort.sv ====
`timescale 1ns/10ps

module storePort (
  input  logic             clock,
  input  logic             rstN,
  // From the sequencer
  input  logic             inValid,
  input  memPkg::memAddr_t inAddr,
  input  isaPkg::word_t    inData,
  output logic             inReady,
  // Toward the outside
  input  logic             outReady,
  output logic             outValid,
  output memPkg::memAddr_t outAddr,
  output isaPkg::word_t    outData
);

  // One entry, accepts only when empty
  assign inReady = !outValid;

  // Occupancy flag
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (inValid && inReady) begin
      outValid <= 1'b1;
    end else if (outValid && outReady) begin
      outValid <= 1'b0;
    end
  end

  // Held stable until the outside takes it
  always_ff @(posedge clock) begin
    if (inValid && inReady) begin
      outAddr <= inAddr;
      outData <= inData;
    end
  end

endmodule

// ==== src/wordMemory.sv ====
`timescale 1ns/10ps

module wordMemory (
  input  logic             clock,
  // Program load port, used while idle
  input  logic             loadEn,
  input  memPkg::memAddr_t loadAddr,
  input  isaPkg::word_t    loadData,
  // Processor port
  input  memPkg::memAddr_t rdAddr,
  input  logic             wrEn,
  input  memPkg::memAddr_t wrAddr,
  input  isaPkg::word_t    wrData,
  output isaPkg::word_t    rdData
);
  import isaPkg::*;
  import memPkg::*;

  // Storage array, contents come only from the load port or stores
  word_t mem [memWords];

  // Single write per cycle
  // Load and store never overlap since loads happen only while idle
  always_ff @(posedge clock) begin
    if (loadEn) begin
      mem[loadAddr] <= loadData;
    end else if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Registered read, data one cycle after the address
  // A read of the address being written returns the old word
  always_ff @(posedge clock) begin
    rdData <= mem[rdAddr];
  end

endmodule

// ==== tb/cpuTop_chk.sv ====
`timescale 1ns/10ps

module cpuTop_chk (
  input logic             clock,
  input logic             rstN,
  input logic             start,
  input logic             loadReady,
  input logic             storeValid,
  input logic             storeReady,
  input logic             halted,
  input memPkg::memAddr_t storeAddr,
  input isaPkg::word_t    storeData
);

  // Read by the testbench for its closing report
  int failCount = 0;

  // A waiting store keeps its address and data
  assert property (@(posedge clock) disable iff (!rstN)
    storeValid && !storeReady |=> storeValid && $stable(storeAddr) && $stable(storeData))
  else begin
    failCount++;
    $error("store port changed its word while storeReady was low");
  end

  // Nothing leaves the processor once it has halted
  assert property (@(posedge clock) disable iff (!rstN)
    halted |-> !(storeValid && storeReady))
  else begin
    failCount++;
    $error("a store was accepted after halted rose");
  end

  // Load port closes at start and stays closed
  assert property (@(posedge clock) disable iff (!rstN)
    (start || !loadReady) |=> !loadReady)
  else begin
    failCount++;
    $error("loadReady went high again after start");
  end

endmodule

bind cpuTop cpuTop_chk i_cpuTop_chk (.*);

// ==== tb/cpuTop_tb.sv ====
`timescale 1ns/10ps

module cpuTop_tb;
  import isaPkg::*;
  import memPkg::*;

  localparam int loadTimeout = 50;
  localparam int haltTimeout = 5000;

  logic clock;
  logic rstN;
  logic start;
  logic loadValid;
  memAddr_t loadAddr;
  word_t loadData;
  logic loadReady;
  logic storeReady;
  logic storeValid;
  memAddr_t storeAddr;
  word_t storeData;
  logic halted;
  word_t acc;

  int mismatchCount;
  int storeCount;
  int otherErrors;
  int assertFails;
  logic timedOut;
  logic sawStart;
  integer seed = 32'h5a4d_461d;
  word_t finalAcc;
  // Program image from the trace
  memAddr_t progAddrQ[$];
  word_t progDataQ[$];

  cpuTop i_cpuTop (
    .clock(clock), .rstN(rstN), .start(start), .loadValid(loadValid),
    .loadAddr(loadAddr), .loadData(loadData), .loadReady(loadReady),
    .storeReady(storeReady), .storeValid(storeValid), .storeAddr(storeAddr),
    .storeData(storeData), .halted(halted), .acc(acc)
  );

  storeMonitor monitor (
    .clock(clock), .rstN(rstN), .storeValid(storeValid), .storeReady(storeReady),
    .storeAddr(storeAddr), .storeData(storeData), .acc(acc),
    .mismatchCount(mismatchCount), .storeCount(storeCount)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Random back-pressure, ready about three cycles in four
  always @(posedge clock) begin
    if (rstN) begin
      storeReady <= ($random(seed) & 3) != 0;
    end
  end

  task automatic readTrace();
    int fd;
    int code;
    logic [63:0] tag;
    logic [8*128-1:0] restOfLine;
    memAddr_t addr;
    word_t data;
    fd = $fopen("tb/fibTrace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/fibTrace.txt");
      otherErrors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tag);
        if (code == 1) begin
          if (tag == "#") begin
            code = $fgets(restOfLine, fd);
          end else if (tag == "L") begin
            code = $fscanf(fd, "%h %h", addr, data);
            progAddrQ.push_back(addr);
            progDataQ.push_back(data);
          end else if (tag == "E") begin
            code = $fscanf(fd, "%h %h", addr, data);
            monitor.pushExpected(addr, data);
          end else if (tag == "A") begin
            code = $fscanf(fd, "%h", data);
            finalAcc = data;
          end else if (tag == "S") begin
            sawStart = 1'b1;
          end else begin
            $display("The trace file holds a record of unknown kind");
            otherErrors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic waitLoadReady();
    int cycles;
    cycles = 0;
    while (!loadReady && cycles < loadTimeout) begin
      @(posedge clock);
      cycles++;
    end
    if (!loadReady) begin
      $display("Timeout: loadReady stayed low for %0d cycles", loadTimeout);
      otherErrors++;
      timedOut = 1'b1;
    end
  endtask

  // One word per cycle through the load port
  task automatic loadProgram();
    int i;
    for (i = 0; i < progAddrQ.size() && !timedOut; i++) begin
      waitLoadReady();
      @(posedge clock);
      loadValid <= 1'b1;
      loadAddr <= progAddrQ[i];
      loadData <= progDataQ[i];
    end
    @(posedge clock);
    loadValid <= 1'b0;
  endtask

  task automatic waitHalted();
    int cycles;
    cycles = 0;
    while (!halted && cycles < haltTimeout) begin
      @(posedge clock);
      cycles++;
    end
    if (!halted) begin
      $display("Timeout: halted did not rise within %0d cycles", haltTimeout);
      otherErrors++;
      timedOut = 1'b1;
    end
  endtask

  initial begin
    rstN = 1'b0;
    start = 1'b0;
    loadValid = 1'b0;
    loadAddr = '0;
    loadData = '0;
    storeReady = 1'b0;
    timedOut = 1'b0;
    sawStart = 1'b0;
    otherErrors = 0;
    finalAcc = '0;
    readTrace();
    repeat (16) @(posedge clock);
    rstN <= 1'b1;
    @(posedge clock);
    loadProgram();
    if (!sawStart) begin
      $display("The trace file has no start record, the run was not started");
      otherErrors++;
    end else if (!timedOut) begin
      // One-cycle start pulse, loadValid already low
      start <= 1'b1;
      @(posedge clock);
      start <= 1'b0;
      waitHalted();
      if (!timedOut) begin
        // Mid-cycle, after the monitor has handled the last edge
        @(negedge clock);
        monitor.finalCheck(finalAcc);
      end
    end
    assertFails = i_cpuTop.i_cpuTop_chk.failCount;
    $display("Stores accepted %0d, mismatches %0d, assertion failures %0d, other errors %0d",
             storeCount, mismatchCount, assertFails, otherErrors);
    if (mismatchCount + assertFails + otherErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb/fibTrace.txt ====
# L addr data = program or data word, S = start, E addr data = expected store
# A value = expected final acc, all numbers in hex
L 00 60000040
L 01 70000050
L 02 20000041
L 03 70000051
L 04 30000042
L 05 70000052
L 06 40000000
L 07 70000053
L 08 10000043
L 09 70000054
L 0a 00000044
L 0b 70000055
L 0c 60000040
L 0d 80000000
L 0e 70000056
L 0f f0000000
L 10 60000060
L 11 00000061
L 12 70000060
L 13 00000061
L 14 70000061
L 15 60000062
L 16 10000063
L 17 70000062
L 18 90000000
L 19 a0000010
L 1a 60000061
L 1b 50000000
L 40 12345678
L 41 0f0f0f0f
L 42 f0000000
L 43 10000000
L 44 02040609
L 60 00000000
L 61 00000001
L 62 00000004
L 63 00000001
S
E 50 12345678
E 51 02040608
E 52 f2040608
E 53 0dfbf9f7
E 54 fdfbf9f7
E 55 00000000
E 56 00000000
E 60 00000001
E 61 00000002
E 62 00000003
E 60 00000003
E 61 00000005
E 62 00000002
E 60 00000008
E 61 0000000d
E 62 00000001
E 60 00000015
E 61 00000022
E 62 00000000
A 00000022

// ==== tb/storeMonitor.sv ====
`timescale 1ns/10ps

module storeMonitor (
  input  logic             clock,
  input  logic             rstN,
  input  logic             storeValid,
  input  logic             storeReady,
  input  memPkg::memAddr_t storeAddr,
  input  isaPkg::word_t    storeData,
  input  isaPkg::word_t    acc,
  output int               mismatchCount,
  output int               storeCount
);
  import isaPkg::*;
  import memPkg::*;

  // Expected stores in program order
  memAddr_t expAddrQ[$];
  word_t expDataQ[$];

  initial begin
    mismatchCount = 0;
    storeCount = 0;
  end

  task automatic pushExpected(input memAddr_t addr, input word_t data);
    expAddrQ.push_back(addr);
    expDataQ.push_back(data);
  endtask

  // One compare per accepted transfer, oldest expectation first
  always @(posedge clock) begin
    if (rstN && storeValid && storeReady) begin
      storeCount++;
      if (expAddrQ.size() == 0) begin
        mismatchCount++;
        $display("Fail at %0t: unexpected store to %h with %h", $time, storeAddr, storeData);
      end else begin
        if (storeAddr !== expAddrQ[0] || storeData !== expDataQ[0]) begin
          mismatchCount++;
          $display("Fail at %0t: store %0d went to %h with %h, expected %h with %h",
                   $time, storeCount, storeAddr, storeData, expAddrQ[0], expDataQ[0]);
        end
        void'(expAddrQ.pop_front());
        void'(expDataQ.pop_front());
      end
    end
  end

  // Called once the processor has halted
  task automatic finalCheck(input word_t expAcc);
    if (expAddrQ.size() != 0) begin
      mismatchCount += expAddrQ.size();
      $display("Fail at %0t: %0d expected stores never arrived", $time, expAddrQ.size());
    end
    if (acc !== expAcc) begin
      mismatchCount++;
      $display("Fail at %0t: final acc %h, expected %h", $time, acc, expAcc);
    end
  endtask

endmodule
